//--- compile.f
source/lc3b_types.sv
source/lc3b_ctrl.sv
source/control_rom.sv
source/regfile.sv
source/alu.sv
source/ifid.sv
source/memwb.sv
source/cpu_datapath.sv
verif/tb_clock.sv
verif/cpu_assertions.sv
verif/tb_cpu.sv

//--- source/alu.sv
`timescale 1ns/1ps

module alu
  import lc3b_types::*;
  import lc3b_ctrl::*;
(
  input  lc3b_aluop aluop,
  input  lc3b_word  a,
  input  lc3b_word  b,
  output lc3b_word  f
);

  always_comb begin
    case (aluop)
      alu_add: begin
        f = a + b;
      end
      alu_and: begin
        f = a & b;
      end
      alu_not: begin
        f = ~a;
      end
      default: begin
        // alu_pass.
        f = b;
      end
    endcase
  end

endmodule : alu

//--- source/control_rom.sv
`timescale 1ns/1ps

module control_rom
  import lc3b_types::*;
  import lc3b_ctrl::*;
(
  input  lc3b_opcode       opcode,
  input  logic [2:0]       mode_bits,
  output lc3b_control_word ctrl
);

  // mode_bits holds nzp for br, and the immediate flag in bit 0 otherwise.
  always_comb begin
    ctrl = nop_ctrl;
    ctrl.opcode = opcode;
    case (opcode)
      op_add: begin
        ctrl.aluop = alu_add;
        ctrl.alumux_sel = mode_bits[0] ? alumux_imm : alumux_sr2;
        ctrl.load_regfile = 1'b1;
        ctrl.load_cc = 1'b1;
        ctrl.regfilemux_sel = regfilemux_alu;
      end
      op_and: begin
        ctrl.aluop = alu_and;
        ctrl.alumux_sel = mode_bits[0] ? alumux_imm : alumux_sr2;
        ctrl.load_regfile = 1'b1;
        ctrl.load_cc = 1'b1;
        ctrl.regfilemux_sel = regfilemux_alu;
      end
      op_not: begin
        ctrl.aluop = alu_not;
        ctrl.load_regfile = 1'b1;
        ctrl.load_cc = 1'b1;
        ctrl.regfilemux_sel = regfilemux_alu;
      end
      op_ldr: begin
        ctrl.mem_read = 1'b1;
        ctrl.load_regfile = 1'b1;
        ctrl.load_cc = 1'b1;
        ctrl.regfilemux_sel = regfilemux_mem;
      end
      op_str: begin
        // source register sits in the dest field.
        ctrl.storemux_sel = 1'b1;
        ctrl.mem_write = 1'b1;
      end
      op_br: begin
        ctrl.branch = 1'b1;
        ctrl.nzp = mode_bits;
      end
      default: begin
        // unsupported, stays a bubble.
        ctrl = nop_ctrl;
        ctrl.opcode = opcode;
      end
    endcase
  end

endmodule : control_rom

//--- source/cpu_datapath.sv
`timescale 1ns/1ps

module cpu_datapath
  import lc3b_types::*;
  import lc3b_ctrl::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  lc3b_word instr,
  input  lc3b_word mem_rdata,
  input  logic     instruction_response,
  input  logic     data_response,
  output lc3b_word instruction_address,
  output lc3b_word mem_address,
  output lc3b_word write_data,
  output logic     instruction_request,
  output logic     data_request,
  output logic     write_enable
);

  logic advance, ready_ifid, ready_memwb, branch_taken;
  lc3b_word pc_q, id_pc, id_sr1, id_sr2, id_imm, id_off, wb_alu, wb_mem_data, wb_data;
  lc3b_word ex_pc, ex_sr1, ex_sr2, ex_imm, ex_off, ex_alu, ex_addr, ex_bmux;
  lc3b_word mem_alu, mem_addr, mem_store;
  lc3b_reg id_dest, id_src1, id_src2, id_srcb, ex_dest, mem_dest, wb_dest;
  lc3b_offset6 id_off6;
  lc3b_offset9 id_off9;
  lc3b_imm5 id_imm5;
  lc3b_cc cc_q, cc_next;
  lc3b_opcode fetch_op;
  logic [2:0] mode_bits;
  lc3b_control_word fetch_ctrl, id_ctrl, ex_ctrl, mem_ctrl, wb_ctrl;

  // id/ex and ex/mem never stall.
  assign advance = ready_ifid && ready_memwb;
  assign instruction_address = pc_q;

  //////////////////////////////////////////////////////////////
  // fetch and decode.
  //////////////////////////////////////////////////////////////
  assign fetch_op = lc3b_opcode'(instr[15:12]);
  assign mode_bits = (fetch_op == op_br) ? instr[11:9] : {2'b00, instr[5]};

  control_rom i_control_rom (.opcode(fetch_op), .mode_bits, .ctrl(fetch_ctrl));

  ifid i_ifid (
    .clk, .rst_n, .advance, .instr, .instruction_response,
    .pc_in(pc_q), .ctrl_in(fetch_ctrl), .instruction_request, .pc(id_pc), .ir(),
    .dest(id_dest), .src1(id_src1), .src2(id_src2), .offset6(id_off6),
    .offset9(id_off9), .imm5(id_imm5), .ctrl_out(id_ctrl), .ready(ready_ifid)
  );

  // str reads its data register through port b.
  assign id_srcb = id_ctrl.storemux_sel ? id_dest : id_src2;

  regfile i_regfile (
    .clk, .rst_n, .load(advance && wb_ctrl.load_regfile), .in(wb_data),
    .src_a(id_src1), .src_b(id_srcb), .dest(wb_dest), .reg_a(id_sr1), .reg_b(id_sr2)
  );

  // word offsets scaled to bytes.
  assign id_imm = {{11{id_imm5[4]}}, id_imm5};
  assign id_off = id_ctrl.branch ? {{6{id_off9[8]}}, id_off9, 1'b0}
                                 : {{9{id_off6[5]}}, id_off6, 1'b0};

  //////////////////////////////////////////////////////////////
  // execute.
  //////////////////////////////////////////////////////////////
  assign ex_bmux = (ex_ctrl.alumux_sel == alumux_imm) ? ex_imm : ex_sr2;

  alu i_alu (.aluop(ex_ctrl.aluop), .a(ex_sr1), .b(ex_bmux), .f(ex_alu));

  // br target rides the address path into mem/wb.
  assign ex_addr = (ex_ctrl.branch ? ex_pc : ex_sr1) + ex_off;

  memwb i_memwb (
    .clk, .rst_n, .advance, .ctrl_in(mem_ctrl), .alu_in(mem_alu), .addr_in(mem_addr),
    .store_in(mem_store), .dest_in(mem_dest), .mem_rdata, .data_response,
    .data_request, .write_enable, .mem_address, .write_data, .ctrl_out(wb_ctrl),
    .alu_out(wb_alu), .mem_data_out(wb_mem_data), .dest_out(wb_dest), .ready(ready_memwb)
  );

  //////////////////////////////////////////////////////////////
  // writeback, condition codes and branch.
  //////////////////////////////////////////////////////////////
  assign wb_data = (wb_ctrl.regfilemux_sel == regfilemux_mem) ? wb_mem_data : wb_alu;

  always_comb begin
    if (wb_data[15]) cc_next = 3'b100;
    else if (wb_data == '0) cc_next = 3'b010;
    else cc_next = 3'b001;
  end

  assign branch_taken = wb_ctrl.branch && |(wb_ctrl.nzp & cc_q);

  // z after reset so an unconditional br works from the start.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= reset_pc;
      cc_q <= 3'b010;
      ex_ctrl <= nop_ctrl;
      mem_ctrl <= nop_ctrl;
    end else if (advance) begin
      pc_q <= branch_taken ? mem_address : id_pc;
      if (wb_ctrl.load_cc) cc_q <= cc_next;
      ex_ctrl <= id_ctrl;
      mem_ctrl <= ex_ctrl;
    end
  end

  // id/ex and ex/mem payload.
  always_ff @(posedge clk) begin
    if (advance) begin
      ex_pc <= id_pc;
      ex_sr1 <= id_sr1;
      ex_sr2 <= id_sr2;
      ex_imm <= id_imm;
      ex_off <= id_off;
      ex_dest <= id_dest;
      mem_alu <= ex_alu;
      mem_addr <= ex_addr;
      mem_store <= ex_sr2;
      mem_dest <= ex_dest;
    end
  end

endmodule : cpu_datapath

//--- source/ifid.sv
`timescale 1ns/1ps

module ifid
  import lc3b_types::*;
  import lc3b_ctrl::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             advance,
  input  lc3b_word         instr,
  input  logic             instruction_response,
  input  lc3b_word         pc_in,
  input  lc3b_control_word ctrl_in,
  output logic             instruction_request,
  output lc3b_word         pc,
  output lc3b_word         ir,
  output lc3b_reg          dest,
  output lc3b_reg          src1,
  output lc3b_reg          src2,
  output lc3b_offset6      offset6,
  output lc3b_offset9      offset9,
  output lc3b_imm5         imm5,
  output lc3b_control_word ctrl_out,
  output logic             ready
);

  typedef enum logic [1:0] {
    idle,
    wait_resp,
    holding
  } fetch_state_e;

  fetch_state_e     state;
  lc3b_word         ir_q;
  lc3b_word         pc_q;
  lc3b_control_word ctrl_q;

  logic capture;

  assign capture = (state == wait_resp) && instruction_response;

  //////////////////////////////////////////////////////////////
  // fetch fsm.
  //////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= idle;
      ctrl_q <= nop_ctrl;
    end else begin
      case (state)
        idle: state <= wait_resp;
        wait_resp: begin
          if (instruction_response) begin
            state <= holding;
            ctrl_q <= ctrl_in;
          end
        end
        // next fetch goes out right after the hand-off.
        holding: if (advance) state <= wait_resp;
        default: state <= idle;
      endcase
    end
  end

  // pc kept as the incremented value, base for br targets.
  always_ff @(posedge clk) begin
    if (capture) begin
      ir_q <= instr;
      pc_q <= pc_in + pc_step;
    end
  end

  assign instruction_request = (state == wait_resp);
  assign ready = (state == holding);

  assign pc = pc_q;
  assign ir = ir_q;
  assign ctrl_out = ctrl_q;
  assign dest = ir_q[11:9];
  assign src1 = ir_q[8:6];
  assign src2 = ir_q[2:0];
  assign offset6 = ir_q[5:0];
  assign offset9 = ir_q[8:0];
  assign imm5 = ir_q[4:0];

endmodule : ifid

//--- source/lc3b_ctrl.sv
package lc3b_ctrl;
  import lc3b_types::*;

  typedef enum logic [1:0] {
    alu_add,
    alu_and,
    alu_not,
    alu_pass
  } lc3b_aluop;

  // alu b operand select.
  localparam logic alumux_sr2 = 1'b0;
  localparam logic alumux_imm = 1'b1;

  // writeback source select.
  localparam logic regfilemux_alu = 1'b0;
  localparam logic regfilemux_mem = 1'b1;

  // one control word per instruction, carried through every stage.
  typedef struct packed {
    lc3b_opcode opcode;
    lc3b_aluop  aluop;
    logic       alumux_sel;
    logic       storemux_sel;   // read dest field on port b.
    logic       load_regfile;
    logic       load_cc;
    logic       mem_read;
    logic       mem_write;
    logic       regfilemux_sel;
    logic       branch;
    lc3b_cc     nzp;
  } lc3b_control_word;

  // bubble, nothing enabled.
  localparam lc3b_control_word nop_ctrl = '{
    opcode:         op_br,
    aluop:          alu_pass,
    alumux_sel:     alumux_sr2,
    storemux_sel:   1'b0,
    load_regfile:   1'b0,
    load_cc:        1'b0,
    mem_read:       1'b0,
    mem_write:      1'b0,
    regfilemux_sel: regfilemux_alu,
    branch:         1'b0,
    nzp:            3'b000
  };

endpackage : lc3b_ctrl

//--- source/lc3b_types.sv
package lc3b_types;

  // data and address words.
  typedef logic [15:0] lc3b_word;

  // register index.
  typedef logic [2:0] lc3b_reg;

  // signed instruction fields.
  typedef logic signed [5:0] lc3b_offset6;
  typedef logic signed [8:0] lc3b_offset9;
  typedef logic signed [4:0] lc3b_imm5;

  // nzp condition flags.
  typedef logic [2:0] lc3b_cc;

  // instr[15:12] encodings.
  typedef enum logic [3:0] {
    op_br   = 4'b0000,
    op_add  = 4'b0001,
    op_ldb  = 4'b0010,
    op_stb  = 4'b0011,
    op_jsr  = 4'b0100,
    op_and  = 4'b0101,
    op_ldr  = 4'b0110,
    op_str  = 4'b0111,
    op_rti  = 4'b1000,
    op_not  = 4'b1001,
    op_ldi  = 4'b1010,
    op_sti  = 4'b1011,
    op_jmp  = 4'b1100,
    op_shf  = 4'b1101,
    op_lea  = 4'b1110,
    op_trap = 4'b1111
  } lc3b_opcode;

  localparam int num_regs = 8;

  // first fetch address.
  localparam lc3b_word reset_pc = 16'h0000;

  // instructions are one word, two bytes.
  localparam lc3b_word pc_step = 16'd2;

endpackage : lc3b_types

//--- source/memwb.sv
`timescale 1ns/1ps

module memwb
  import lc3b_types::*;
  import lc3b_ctrl::*;
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             advance,
  input  lc3b_control_word ctrl_in,
  input  lc3b_word         alu_in,
  input  lc3b_word         addr_in,
  input  lc3b_word         store_in,
  input  lc3b_reg          dest_in,
  input  lc3b_word         mem_rdata,
  input  logic             data_response,
  output logic             data_request,
  output logic             write_enable,
  output lc3b_word         mem_address,
  output lc3b_word         write_data,
  output lc3b_control_word ctrl_out,
  output lc3b_word         alu_out,
  output lc3b_word         mem_data_out,
  output lc3b_reg          dest_out,
  output logic             ready
);

  typedef enum logic [1:0] {
    idle,
    wait_resp,
    done
  } mem_state_e;

  mem_state_e       state;
  lc3b_control_word ctrl_q;
  lc3b_word         alu_q;
  lc3b_word         addr_q;
  lc3b_word         store_q;
  lc3b_word         rdata_q;
  lc3b_reg          dest_q;

  // idle here means the held instruction needs no memory.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= idle;
      ctrl_q <= nop_ctrl;
    end else if (advance) begin
      ctrl_q <= ctrl_in;
      state <= (ctrl_in.mem_read || ctrl_in.mem_write) ? wait_resp : idle;
    end else if ((state == wait_resp) && data_response) begin
      state <= done;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      alu_q <= alu_in;
      addr_q <= addr_in;
      store_q <= store_in;
      dest_q <= dest_in;
    end
    if ((state == wait_resp) && data_response) begin
      rdata_q <= mem_rdata;
    end
  end

  assign data_request = (state == wait_resp);
  assign write_enable = data_request && ctrl_q.mem_write;
  assign ready = (state != wait_resp);

  assign mem_address = addr_q;
  assign write_data = store_q;
  assign ctrl_out = ctrl_q;
  assign alu_out = alu_q;
  assign mem_data_out = rdata_q;
  assign dest_out = dest_q;

endmodule : memwb

//--- source/regfile.sv
`timescale 1ns/1ps

module regfile
  import lc3b_types::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     load,
  input  lc3b_word in,
  input  lc3b_reg  src_a,
  input  lc3b_reg  src_b,
  input  lc3b_reg  dest,
  output lc3b_word reg_a,
  output lc3b_word reg_b
);

  lc3b_word regs [num_regs];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (load) begin
      regs[dest] <= in;
    end
  end

  // write-through so decode sees the committing value.
  assign reg_a = (load && (src_a == dest)) ? in : regs[src_a];
  assign reg_b = (load && (src_b == dest)) ? in : regs[src_b];

endmodule : regfile

//--- verif/cpu_assertions.sv
`timescale 1ns/1ps

module cpu_assertions
  import lc3b_types::*;
(
  input logic     clk,
  input logic     rst_n,
  input logic     instruction_request,
  input logic     instruction_response,
  input logic     data_request,
  input logic     data_response,
  input logic     write_enable,
  input lc3b_word instruction_address,
  input lc3b_word mem_address,
  input lc3b_word write_data
);

  int failures = 0;

  // fetch request and address hold until the response.
  instr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    instruction_request && !instruction_response
      |=> instruction_request && $stable(instruction_address))
    else begin
      failures++;
      $error("instruction request or address changed before its response");
    end

  data_hold: assert property (@(posedge clk) disable iff (!rst_n)
    data_request && !data_response
      |=> data_request && $stable(mem_address) && $stable(write_data)
          && $stable(write_enable))
    else begin
      failures++;
      $error("data request, address or write data changed before its response");
    end

  // request drops right after the response.
  instr_drop: assert property (@(posedge clk) disable iff (!rst_n)
    instruction_response |=> !instruction_request)
    else begin
      failures++;
      $error("instruction request still high after its response");
    end

  data_drop: assert property (@(posedge clk) disable iff (!rst_n)
    data_response |=> !data_request)
    else begin
      failures++;
      $error("data request still high after its response");
    end

  // write_enable only comes up with a fresh data request.
  write_with_request: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(write_enable) |-> $rose(data_request))
    else begin
      failures++;
      $error("write_enable raised without a new data_request");
    end

endmodule : cpu_assertions

//--- verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst_n
);

  // 40 ns period.
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule : tb_clock

//--- verif/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu
  import lc3b_types::*;
();

  localparam int max_delay = 4;
  localparam int mem_words = 256;
  // program words over all runs, each with three trailing nops.
  localparam int total_instrs = (15 + 3) + (8 + 3) + 6 * (10 + 3) + 2 * (23 + 3);
  localparam real watchdog_ns = 200.0 * total_instrs * max_delay * 40.0;

  logic clk, clk_rst_n, rst_n;
  logic tb_rst_n = 1'b1;
  lc3b_word instr = '0;
  lc3b_word mem_rdata = '0;
  logic instruction_response = 1'b0;
  logic data_response = 1'b0;
  lc3b_word instruction_address, mem_address, write_data;
  logic instruction_request, data_request, write_enable;

  lc3b_word imem [mem_words];
  lc3b_word dmem [mem_words];
  lc3b_word prog [$];
  lc3b_word seen_addr [$];
  lc3b_word seen_data [$];
  lc3b_word exp_addr [$];
  lc3b_word exp_data [$];
  int seed = 32'hb41e4c55;
  int errors = 0;
  int checks = 0;
  bit fixed_delay = 1'b0;
  int i_left, d_left;
  bit i_armed, d_armed;

  assign rst_n = clk_rst_n && tb_rst_n;

  tb_clock i_clock (.clk, .rst_n(clk_rst_n));

  cpu_datapath i_dut (
    .clk, .rst_n, .instr, .mem_rdata, .instruction_response, .data_response,
    .instruction_address, .mem_address, .write_data, .instruction_request,
    .data_request, .write_enable
  );

  bind cpu_datapath cpu_assertions i_cpu_assertions (.*);

  function automatic int draw_delay();
    if (fixed_delay) return 1;
    return ({$random(seed)} % max_delay) + 1;
  endfunction

  //////////////////////////////////////////////////////////////
  // memory models.
  //////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (!rst_n) begin
      instruction_response <= 1'b0;
      i_armed <= 1'b0;
    end else if (instruction_response) begin
      instruction_response <= 1'b0;
    end else if (instruction_request) begin
      if (!i_armed) begin
        i_armed <= 1'b1;
        i_left <= draw_delay() - 1;
      end else if (i_left == 0) begin
        i_armed <= 1'b0;
        instruction_response <= 1'b1;
        instr <= imem[instruction_address[8:1]];
      end else begin
        i_left <= i_left - 1;
      end
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      data_response <= 1'b0;
      d_armed <= 1'b0;
    end else if (data_response) begin
      data_response <= 1'b0;
    end else if (data_request) begin
      if (!d_armed) begin
        d_armed <= 1'b1;
        d_left <= draw_delay() - 1;
      end else if (d_left == 0) begin
        d_armed <= 1'b0;
        data_response <= 1'b1;
        if (write_enable) begin
          dmem[mem_address[8:1]] <= write_data;
          seen_addr.push_back(mem_address);
          seen_data.push_back(write_data);
        end else begin
          mem_rdata <= dmem[mem_address[8:1]];
        end
      end else begin
        d_left <= d_left - 1;
      end
    end
  end

  //////////////////////////////////////////////////////////////
  // instruction encoding.
  //////////////////////////////////////////////////////////////
  function automatic lc3b_word add_rr(lc3b_reg d, lc3b_reg a, lc3b_reg b);
    return {op_add, d, a, 3'b000, b};
  endfunction

  function automatic lc3b_word add_ri(lc3b_reg d, lc3b_reg a, int imm);
    return {op_add, d, a, 1'b1, 5'(imm)};
  endfunction

  function automatic lc3b_word and_rr(lc3b_reg d, lc3b_reg a, lc3b_reg b);
    return {op_and, d, a, 3'b000, b};
  endfunction

  function automatic lc3b_word and_ri(lc3b_reg d, lc3b_reg a, int imm);
    return {op_and, d, a, 1'b1, 5'(imm)};
  endfunction

  function automatic lc3b_word not_r(lc3b_reg d, lc3b_reg a);
    return {op_not, d, a, 6'b111111};
  endfunction

  function automatic lc3b_word ldr_w(lc3b_reg d, lc3b_reg base, int off);
    return {op_ldr, d, base, 6'(off)};
  endfunction

  function automatic lc3b_word str_w(lc3b_reg s, lc3b_reg base, int off);
    return {op_str, s, base, 6'(off)};
  endfunction

  function automatic lc3b_word br_to(lc3b_cc nzp, int off);
    return {op_br, nzp, 9'(off)};
  endfunction

  //////////////////////////////////////////////////////////////
  // checks.
  //////////////////////////////////////////////////////////////
  task automatic compare_word(input string name, input lc3b_word expected,
                              input lc3b_word actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic compare_addr(input string name, input lc3b_word expected,
                              input lc3b_word actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s address expected %h, got %h",
               $time, name, expected, actual);
    end
  endtask

  task automatic compare_bit(input string name, input logic expected, input logic actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("CHECK FAILED at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  task automatic expect_store(input lc3b_word addr, input lc3b_word data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endtask

  task automatic check_writes(input string name);
    if (seen_addr.size() != exp_addr.size()) begin
      errors++;
      $display("%s: expected %0d stores but saw %0d", name, exp_addr.size(), seen_addr.size());
    end else begin
      foreach (exp_addr[i]) begin
        compare_addr({name, " store"}, exp_addr[i], seen_addr[i]);
        compare_word({name, " write_data"}, exp_data[i], seen_data[i]);
      end
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    tb_rst_n <= 1'b0;
    repeat (5) @(posedge clk);
    tb_rst_n <= 1'b1;
  endtask

  // runs prog until the fetch just past its trailing nops.
  task automatic run_program(input string name);
    lc3b_word sentinel;
    int limit;
    int cycles;
    bit reached;
    sentinel = lc3b_word'((prog.size() + 3) * 2);
    limit = 200 * (prog.size() + 3) * max_delay;
    cycles = 0;
    reached = 1'b0;
    foreach (imem[i]) imem[i] = 16'h0000;
    foreach (prog[i]) imem[i] = prog[i];
    seen_addr.delete();
    seen_data.delete();
    apply_reset();
    while (!reached && cycles < limit) begin
      @(negedge clk);
      cycles++;
      reached = instruction_request && (instruction_address == sentinel);
    end
    if (!reached) begin
      errors++;
      $display("%s hung: end address not fetched within %0d cycles", name, limit);
    end
  endtask

  //////////////////////////////////////////////////////////////
  // programs.
  //////////////////////////////////////////////////////////////
  task automatic build_alu_program();
    lc3b_word a;
    lc3b_word b;
    a = 16'd13;
    b = lc3b_word'(-7);
    prog.push_back(add_ri(1, 0, 13));
    prog.push_back(add_ri(2, 0, -7));
    prog.push_back(16'h0000);
    prog.push_back(16'h0000);
    prog.push_back(add_rr(3, 1, 2));
    prog.push_back(add_ri(4, 1, 5));
    prog.push_back(and_rr(5, 1, 2));
    prog.push_back(and_ri(6, 2, -4));
    prog.push_back(not_r(7, 1));
    prog.push_back(16'h0000);
    for (int r = 3; r < 8; r++) prog.push_back(str_w(r, 0, r + 5));
    expect_store(16'd16, a + b);
    expect_store(16'd18, a + 16'd5);
    expect_store(16'd20, a & b);
    expect_store(16'd22, b & 16'hfffc);
    expect_store(16'd24, ~a);
  endtask

  // loads words 20..23, stores them back at words 28..31.
  task automatic build_load_program();
    for (int r = 1; r < 5; r++) prog.push_back(ldr_w(r, 0, 19 + r));
    for (int r = 1; r < 5; r++) prog.push_back(str_w(r, 0, 27 + r));
    for (int r = 1; r < 5; r++) expect_store(lc3b_word'((27 + r) * 2), dmem[19 + r]);
  endtask

  //////////////////////////////////////////////////////////////
  // tests.
  //////////////////////////////////////////////////////////////
  task automatic test_reset();
    int cycles;
    cycles = 0;
    foreach (imem[i]) imem[i] = 16'h0000;
    apply_reset();
    @(negedge clk);
    compare_bit("instruction_request", 1'b0, instruction_request);
    compare_bit("data_request", 1'b0, data_request);
    compare_bit("write_enable", 1'b0, write_enable);
    while (!instruction_request && cycles < 10) begin
      @(negedge clk);
      cycles++;
    end
    if (!instruction_request) begin
      errors++;
      $display("no instruction request after reset");
    end else begin
      compare_addr("instruction_address", reset_pc, instruction_address);
    end
  endtask

  task automatic test_alu();
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
    build_alu_program();
    run_program("alu");
    check_writes("alu");
  endtask

  task automatic test_loads();
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
    build_load_program();
    run_program("loads");
    check_writes("loads");
  endtask

  // the cc comes from the instruction right before br.
  task automatic test_branches();
    int cc_value [3] = '{-1, 0, 1};
    lc3b_cc flags [3] = '{3'b100, 3'b010, 3'b001};
    string name;
    for (int k = 0; k < 3; k++) begin
      for (int taken = 0; taken < 2; taken++) begin
        name = $sformatf("br nzp=%b taken=%0d", flags[k], taken);
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        prog.push_back(add_ri(2, 0, 7));
        prog.push_back(16'h0000);
        prog.push_back(16'h0000);
        prog.push_back(add_ri(1, 0, taken ? cc_value[k] : cc_value[(k + 1) % 3]));
        prog.push_back(br_to(flags[k], 4));
        for (int s = 1; s < 6; s++) prog.push_back(str_w(2, 0, s));
        for (int s = 1; s < 4; s++) expect_store(lc3b_word'(s * 2), 16'd7);
        if (!taken) expect_store(16'd8, 16'd7);
        expect_store(16'd10, 16'd7);
        run_program(name);
        check_writes(name);
      end
    end
  endtask

  // both runs must produce the same isa-level write sequence.
  task automatic test_delays();
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
    build_alu_program();
    build_load_program();
    fixed_delay = 1'b1;
    run_program("one-cycle memory");
    check_writes("one-cycle memory");
    fixed_delay = 1'b0;
    run_program("random-delay memory");
    check_writes("random-delay memory");
  endtask

  initial begin
    #(watchdog_ns);
    $display("watchdog expired before the tests finished");
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    foreach (dmem[i]) dmem[i] = lc3b_word'($random(seed));
    wait (clk_rst_n === 1'b1);
    test_reset();
    test_alu();
    test_loads();
    test_branches();
    test_delays();
    errors += i_dut.i_cpu_assertions.failures;
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_cpu
